/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_baseline_allocator
FILELIST = list.f

SOURCES = $(wildcard logic/*.sv logic/*.svh verification/*.sv verification/*.svh) $(FILELIST)
BIN     = obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

$(BIN): $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* list.f */
+incdir+logic
+incdir+verification
logic/router_pkg.sv
logic/alloc_pkg.sv
logic/ivc_state_if.sv
logic/rr_arbiter.sv
logic/vc_allocator.sv
logic/sw_allocator.sv
logic/baseline_allocator.sv
verification/tb_baseline_allocator.sv

/* logic/alloc_macros.svh */
`ifndef ALLOC_MACROS_SVH
`define ALLOC_MACROS_SVH

// VCs per port
`define ALLOC_V 2

// router ports
`define ALLOC_P 5

// a port never requests itself
`define ALLOC_P_1 (`ALLOC_P - 1)

`define ALLOC_PV (`ALLOC_V * `ALLOC_P) // input VCs over all ports

`endif

/* logic/alloc_pkg.sv */
`include "alloc_macros.svh"

package alloc_pkg;

    // second stage vector of one output VC, relative port then VC
    typedef logic [`ALLOC_V*`ALLOC_P_1-1:0] ovc_cand_t;

    typedef logic [`ALLOC_PV*`ALLOC_V-1:0] ovc_grant_all_t; // one-hot ovc word per input VC

    // dest vectors of every input VC
    typedef logic [`ALLOC_PV*`ALLOC_P_1-1:0] dest_all_t;

    typedef logic [`ALLOC_P*`ALLOC_P_1-1:0] port_dest_all_t; // granted rel port per input port

endpackage

/* logic/baseline_allocator.sv */
`timescale 1ns/1ps

module baseline_allocator (
    input  logic                      clk,
    input  logic                      reset,
    input  alloc_pkg::dest_all_t      dest_port_all,
    input  router_pkg::ivc_vec_t      ovc_is_assigned_all,
    input  router_pkg::ivc_vec_t      ivc_request_all,
    input  router_pkg::ivc_vec_t      assigned_ovc_not_full_all,
    input  alloc_pkg::ovc_grant_all_t masked_ovc_request_all,
    output router_pkg::ivc_vec_t      ovc_allocated_all,
    output alloc_pkg::ovc_grant_all_t granted_ovc_num_all,
    output router_pkg::ivc_vec_t      ivc_num_getting_ovc_grant,
    output router_pkg::ivc_vec_t      ivc_num_getting_sw_grant,
    output alloc_pkg::port_dest_all_t granted_dest_port_all,
    output router_pkg::port_vec_t     any_ivc_sw_request_granted_all
);
    ivc_state_if u_ivc_state ();

    assign u_ivc_state.ivc_request           = ivc_request_all;
    assign u_ivc_state.ovc_is_assigned       = ovc_is_assigned_all;
    assign u_ivc_state.assigned_ovc_not_full = assigned_ovc_not_full_all;
    assign u_ivc_state.dest_port             = dest_port_all;
    assign u_ivc_state.masked_ovc_request    = masked_ovc_request_all;

    // canonical separable VC allocation
    vc_allocator u_vc_allocator (
        .clk                       (clk),
        .reset                     (reset),
        .ivc                       (u_ivc_state.vc_alloc),
        .granted_ovc_num_all       (granted_ovc_num_all),
        .ovc_allocated_all         (ovc_allocated_all),
        .ivc_num_getting_ovc_grant (ivc_num_getting_ovc_grant)
    );

    // non-speculative switch allocation
    sw_allocator u_sw_allocator (
        .clk                            (clk),
        .reset                          (reset),
        .ivc                            (u_ivc_state.sw_alloc),
        .ivc_num_getting_sw_grant       (ivc_num_getting_sw_grant),
        .granted_dest_port_all          (granted_dest_port_all),
        .any_ivc_sw_request_granted_all (any_ivc_sw_request_granted_all)
    );

endmodule

/* logic/ivc_state_if.sv */
`timescale 1ns/1ps

// input VC state shared by both allocators
interface ivc_state_if;

    router_pkg::ivc_vec_t       ivc_request;
    router_pkg::ivc_vec_t       ovc_is_assigned;
    router_pkg::ivc_vec_t       assigned_ovc_not_full;
    alloc_pkg::dest_all_t       dest_port;
    alloc_pkg::ovc_grant_all_t  masked_ovc_request;

    modport vc_alloc (
        input dest_port,
        input masked_ovc_request
    );

    modport sw_alloc (
        input ivc_request,
        input ovc_is_assigned,
        input assigned_ovc_not_full, // back-pressure from downstream
        input dest_port
    );

endinterface

/* logic/router_pkg.sv */
`include "alloc_macros.svh"

package router_pkg;

    // one bit per VC of a single port
    typedef logic [`ALLOC_V-1:0] vc_vec_t;

    typedef logic [`ALLOC_P-1:0] port_vec_t; // one bit per port

    // one-hot relative destination, the own port is skipped
    typedef logic [`ALLOC_P_1-1:0] dest_vec_t;

    // all input VCs, port-major
    typedef logic [`ALLOC_PV-1:0] ivc_vec_t;

endpackage

/* logic/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] request,
    output logic [width-1:0] grant,
    output logic             any_grant
);
    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    logic [ptr_w-1:0] pointer;      // highest priority index
    logic [ptr_w-1:0] next_pointer;
    logic             found;

    // search upward from the pointer, wrapping around
    always_comb begin
        grant = '0;
        next_pointer = pointer;
        found = 1'b0;
        for (int k = 0; k < width; k++) begin
            if (!found && request[(int'(pointer) + k) % width]) begin
                found = 1'b1;
                grant[(int'(pointer) + k) % width] = 1'b1;
                next_pointer = ptr_w'((int'(pointer) + k + 1) % width);
            end
        end
    end

    assign any_grant = |request;

    // granted index becomes lowest priority
    always_ff @(posedge clk) begin
        if (reset) begin
            pointer <= '0;
        end else if (any_grant) begin
            pointer <= next_pointer;
        end
    end

endmodule

/* logic/sw_allocator.sv */
`timescale 1ns/1ps
`include "alloc_macros.svh"

module sw_allocator (
    input  logic                      clk,
    input  logic                      reset,
    ivc_state_if.sw_alloc             ivc,
    output router_pkg::ivc_vec_t      ivc_num_getting_sw_grant,
    output alloc_pkg::port_dest_all_t granted_dest_port_all,
    output router_pkg::port_vec_t     any_ivc_sw_request_granted_all
);
    router_pkg::ivc_vec_t                eligible;
    router_pkg::vc_vec_t  [`ALLOC_P-1:0] in_grant;
    router_pkg::dest_vec_t [`ALLOC_P-1:0] port_req; // dest of the chosen VC

    // indexed by output port, then relative input port
    logic [`ALLOC_P-1:0][`ALLOC_P_1-1:0] out_req;
    logic [`ALLOC_P-1:0][`ALLOC_P_1-1:0] out_grant;

    // full or unassigned VCs drop out here
    assign eligible = ivc.ivc_request & ivc.ovc_is_assigned & ivc.assigned_ovc_not_full;

    always_comb begin
        port_req = '0;
        for (int p = 0; p < `ALLOC_P; p++) begin
            for (int v = 0; v < `ALLOC_V; v++) begin
                if (in_grant[p][v]) begin
                    port_req[p] = port_req[p] |
                                  ivc.dest_port[(p*`ALLOC_V+v)*`ALLOC_P_1 +: `ALLOC_P_1];
                end
            end
        end
    end

    for (genvar p = 0; p < `ALLOC_P; p++) begin : g_in_port
        rr_arbiter #(
            .width (`ALLOC_V)
        ) u_in_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (eligible[p*`ALLOC_V +: `ALLOC_V]),
            .grant     (in_grant[p]),
            .any_grant ()
        );

        assign any_ivc_sw_request_granted_all[p] =
            |granted_dest_port_all[p*`ALLOC_P_1 +: `ALLOC_P_1];
        assign ivc_num_getting_sw_grant[p*`ALLOC_V +: `ALLOC_V] =
            any_ivc_sw_request_granted_all[p] ? in_grant[p] : '0;
    end

    for (genvar q = 0; q < `ALLOC_P; q++) begin : g_out_port
        for (genvar r = 0; r < `ALLOC_P_1; r++) begin : g_rel
            localparam int ip = (r < q) ? r : r + 1;
            localparam int dk = (q < ip) ? q : q - 1; // q as seen from ip

            assign out_req[q][r] = port_req[ip][dk];
            assign granted_dest_port_all[ip*`ALLOC_P_1+dk] = out_grant[q][r];
        end

        rr_arbiter #(
            .width (`ALLOC_P_1)
        ) u_out_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (out_req[q]),
            .grant     (out_grant[q]),
            .any_grant ()
        );
    end

endmodule

/* logic/vc_allocator.sv */
`timescale 1ns/1ps
`include "alloc_macros.svh"

module vc_allocator (
    input  logic                      clk,
    input  logic                      reset,
    ivc_state_if.vc_alloc             ivc,
    output alloc_pkg::ovc_grant_all_t granted_ovc_num_all,
    output router_pkg::ivc_vec_t      ovc_allocated_all,
    output router_pkg::ivc_vec_t      ivc_num_getting_ovc_grant
);
    router_pkg::vc_vec_t  [`ALLOC_PV-1:0] first_grant;  // chosen ovc per input VC
    alloc_pkg::ovc_cand_t [`ALLOC_PV-1:0] second_req;   // steered candidates per output VC
    alloc_pkg::ovc_cand_t [`ALLOC_PV-1:0] second_grant;

    // per input VC and ovc index, one bit per relative destination port
    logic [`ALLOC_PV*`ALLOC_V*`ALLOC_P_1-1:0] won;

    // first stage, one arbiter per input VC
    for (genvar i = 0; i < `ALLOC_PV; i++) begin : g_ivc
        rr_arbiter #(
            .width (`ALLOC_V)
        ) u_first_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (ivc.masked_ovc_request[i*`ALLOC_V +: `ALLOC_V]),
            .grant     (first_grant[i]),
            .any_grant ()
        );

        for (genvar ov = 0; ov < `ALLOC_V; ov++) begin : g_word
            assign granted_ovc_num_all[i*`ALLOC_V+ov] =
                |won[(i*`ALLOC_V+ov)*`ALLOC_P_1 +: `ALLOC_P_1]; // at most one slot wins
        end

        assign ivc_num_getting_ovc_grant[i] = |granted_ovc_num_all[i*`ALLOC_V +: `ALLOC_V];
    end

    // second stage, one arbiter per output VC
    for (genvar o = 0; o < `ALLOC_PV; o++) begin : g_ovc
        localparam int op = o / `ALLOC_V;
        localparam int ov = o % `ALLOC_V;

        for (genvar r = 0; r < `ALLOC_P_1; r++) begin : g_rel
            // input port seen at relative slot r
            localparam int ip = (r < op) ? r : r + 1;
            // dest bit of that input port pointing back here
            localparam int dk = (op < ip) ? op : op - 1;

            for (genvar iv = 0; iv < `ALLOC_V; iv++) begin : g_cand
                localparam int j = ip * `ALLOC_V + iv;

                assign second_req[o][r*`ALLOC_V+iv] =
                    first_grant[j][ov] & ivc.dest_port[j*`ALLOC_P_1+dk];
                assign won[(j*`ALLOC_V+ov)*`ALLOC_P_1+dk] = second_grant[o][r*`ALLOC_V+iv];
            end
        end

        rr_arbiter #(
            .width (`ALLOC_V*`ALLOC_P_1)
        ) u_second_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (second_req[o]),
            .grant     (second_grant[o]),
            .any_grant (ovc_allocated_all[o])
        );
    end

endmodule

/* verification/alloc_ref_model.svh */
`ifndef ALLOC_REF_MODEL_SVH
`define ALLOC_REF_MODEL_SVH

// mirrored pointers start at index 0
int vc1_ptr[`ALLOC_PV] = '{default: 0};
int vc2_ptr[`ALLOC_PV] = '{default: 0};
int swin_ptr[`ALLOC_P] = '{default: 0};
int swout_ptr[`ALLOC_P] = '{default: 0};
int vc1_nxt[`ALLOC_PV];
int vc2_nxt[`ALLOC_PV];
int swin_nxt[`ALLOC_P];
int swout_nxt[`ALLOC_P];

router_pkg::ivc_vec_t      exp_ovc_alloc;
alloc_pkg::ovc_grant_all_t exp_granted_ovc;
router_pkg::ivc_vec_t      exp_ivc_ovc;
router_pkg::ivc_vec_t      exp_ivc_sw;
alloc_pkg::port_dest_all_t exp_dest;
router_pkg::port_vec_t     exp_any_sw;

// relative dest bit k of input port ip to absolute output port
function automatic int rel_to_abs(input int ip, input int k);
    return (k < ip) ? k : k + 1;
endfunction

// first set bit from ptr upward with wraparound
function automatic int rr_pick(input logic [7:0] req, input int width, input int ptr);
    for (int k = 0; k < width; k++) begin
        if (req[(ptr + k) % width]) return (ptr + k) % width;
    end
    return -1; // nothing requested
endfunction

function automatic void compute_expected(
    input alloc_pkg::dest_all_t      dest,
    input router_pkg::ivc_vec_t      assigned,
    input router_pkg::ivc_vec_t      request,
    input router_pkg::ivc_vec_t      not_full,
    input alloc_pkg::ovc_grant_all_t masked
);
    int first_ovc[`ALLOC_PV];
    int sel_vc[`ALLOC_P];
    logic [`ALLOC_P_1-1:0] port_req[`ALLOC_P];
    logic [7:0] cand;
    int w;
    int ip;
    int j;
    exp_ovc_alloc = '0;
    exp_granted_ovc = '0;
    exp_ivc_ovc = '0;
    exp_ivc_sw = '0;
    exp_dest = '0;
    exp_any_sw = '0;
    for (int i = 0; i < `ALLOC_PV; i++) begin
        first_ovc[i] = rr_pick(8'(masked[i*`ALLOC_V +: `ALLOC_V]), `ALLOC_V, vc1_ptr[i]);
        vc1_nxt[i] = (first_ovc[i] >= 0) ? (first_ovc[i] + 1) % `ALLOC_V : vc1_ptr[i];
    end
    for (int o = 0; o < `ALLOC_PV; o++) begin
        cand = '0;
        for (int p = 0; p < `ALLOC_P; p++) begin
            for (int v = 0; v < `ALLOC_V; v++) begin
                for (int k = 0; k < `ALLOC_P_1; k++) begin
                    if (p != o / `ALLOC_V && first_ovc[p*`ALLOC_V+v] == o % `ALLOC_V &&
                        dest[(p*`ALLOC_V+v)*`ALLOC_P_1+k] && rel_to_abs(p, k) == o / `ALLOC_V)
                        cand[((p < o / `ALLOC_V) ? p : p - 1)*`ALLOC_V+v] = 1'b1;
                end
            end
        end
        w = rr_pick(cand, `ALLOC_V*`ALLOC_P_1, vc2_ptr[o]);
        vc2_nxt[o] = (w >= 0) ? (w + 1) % (`ALLOC_V*`ALLOC_P_1) : vc2_ptr[o];
        if (w >= 0) begin
            ip = rel_to_abs(o / `ALLOC_V, w / `ALLOC_V);
            j = ip*`ALLOC_V + w % `ALLOC_V;
            exp_granted_ovc[j*`ALLOC_V + o % `ALLOC_V] = 1'b1;
            exp_ivc_ovc[j] = 1'b1;
            exp_ovc_alloc[o] = 1'b1;
        end
    end
    // switch allocation starts at the input ports
    for (int p = 0; p < `ALLOC_P; p++) begin
        sel_vc[p] = rr_pick(8'((request & assigned & not_full) >> (p*`ALLOC_V)) & 8'h3,
                            `ALLOC_V, swin_ptr[p]);
        swin_nxt[p] = (sel_vc[p] >= 0) ? (sel_vc[p] + 1) % `ALLOC_V : swin_ptr[p];
        port_req[p] = '0;
        if (sel_vc[p] >= 0) port_req[p] = dest[(p*`ALLOC_V+sel_vc[p])*`ALLOC_P_1 +: `ALLOC_P_1];
    end
    for (int q = 0; q < `ALLOC_P; q++) begin
        cand = '0;
        for (int r = 0; r < `ALLOC_P_1; r++) begin
            for (int k = 0; k < `ALLOC_P_1; k++) begin
                if (port_req[rel_to_abs(q, r)][k] && rel_to_abs(rel_to_abs(q, r), k) == q)
                    cand[r] = 1'b1;
            end
        end
        w = rr_pick(cand, `ALLOC_P_1, swout_ptr[q]);
        swout_nxt[q] = (w >= 0) ? (w + 1) % `ALLOC_P_1 : swout_ptr[q];
        if (w >= 0) begin
            ip = rel_to_abs(q, w);
            exp_dest[ip*`ALLOC_P_1 + ((q < ip) ? q : q - 1)] = 1'b1;
            exp_any_sw[ip] = 1'b1;
            exp_ivc_sw[ip*`ALLOC_V + sel_vc[ip]] = 1'b1;
        end
    end
endfunction

`endif

/* verification/tb_baseline_allocator.sv */
`timescale 1ns/1ps
`include "alloc_macros.svh"

module tb_baseline_allocator;
    logic clk = 1'b0;
    logic reset = 1'b1;
    alloc_pkg::dest_all_t      dest_port_all = '0;
    router_pkg::ivc_vec_t      ovc_is_assigned_all = '0;
    router_pkg::ivc_vec_t      ivc_request_all = '0;
    router_pkg::ivc_vec_t      assigned_ovc_not_full_all = '0;
    alloc_pkg::ovc_grant_all_t masked_ovc_request_all = '0;

    router_pkg::ivc_vec_t      ovc_allocated_all;
    alloc_pkg::ovc_grant_all_t granted_ovc_num_all;
    router_pkg::ivc_vec_t      ivc_num_getting_ovc_grant;
    router_pkg::ivc_vec_t      ivc_num_getting_sw_grant;
    alloc_pkg::port_dest_all_t granted_dest_port_all;
    router_pkg::port_vec_t     any_ivc_sw_request_granted_all;

    int mismatch_errors = 0;
    int rule_errors = 0;
    int cycle_count = 0;
    logic [15:0] lfsr = 16'd39;

    `include "alloc_ref_model.svh"

    baseline_allocator u_baseline_allocator (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            val[b] = lfsr[0];
        end
        return val;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
            mismatch_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic set_dest(input int ivc, input int rel);
        dest_port_all[ivc*`ALLOC_P_1 +: `ALLOC_P_1] = 4'(1 << rel);
    endtask

    // reference check at the falling edge
    always @(negedge clk) begin
        int served;
        compute_expected(dest_port_all, ovc_is_assigned_all, ivc_request_all,
                         assigned_ovc_not_full_all, masked_ovc_request_all);
        compare_value("ovc_allocated_all", 64'(exp_ovc_alloc), 64'(ovc_allocated_all));
        compare_value("granted_ovc_num_all", 64'(exp_granted_ovc), 64'(granted_ovc_num_all));
        compare_value("ivc_num_getting_ovc_grant", 64'(exp_ivc_ovc),
                      64'(ivc_num_getting_ovc_grant));
        compare_value("ivc_num_getting_sw_grant", 64'(exp_ivc_sw), 64'(ivc_num_getting_sw_grant));
        compare_value("granted_dest_port_all", 64'(exp_dest), 64'(granted_dest_port_all));
        compare_value("any_ivc_sw_request_granted_all", 64'(exp_any_sw),
                      64'(any_ivc_sw_request_granted_all));
        if ((ivc_num_getting_sw_grant & ~(ivc_request_all & ovc_is_assigned_all &
             assigned_ovc_not_full_all)) != '0) begin
            $display("switch grant given to an ineligible input VC at %0t", $time);
            rule_errors++;
        end
        for (int q = 0; q < `ALLOC_P; q++) begin
            served = 0;
            for (int p = 0; p < `ALLOC_P; p++) begin
                for (int k = 0; k < `ALLOC_P_1; k++) begin
                    if (granted_dest_port_all[p*`ALLOC_P_1+k] && rel_to_abs(p, k) == q) served++;
                end
            end
            if (served > 1 || $countones(ivc_num_getting_sw_grant[q*`ALLOC_V +: `ALLOC_V]) > 1) begin
                $display("port %0d has more than one switch grant at %0t", q, $time);
                rule_errors++;
            end
        end
    end

    // mirrored pointers follow the DUT at each edge
    always @(posedge clk) begin
        cycle_count++;
        for (int i = 0; i < `ALLOC_PV; i++) begin
            vc1_ptr[i] = reset ? 0 : vc1_nxt[i];
            vc2_ptr[i] = reset ? 0 : vc2_nxt[i];
        end
        for (int p = 0; p < `ALLOC_P; p++) begin
            swin_ptr[p] = reset ? 0 : swin_nxt[p];
            swout_ptr[p] = reset ? 0 : swout_nxt[p];
        end
        if (cycle_count >= 700) begin
            $display("timeout, the run did not finish within 700 cycles");
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        repeat (16) next_cycle();
        reset = 1'b0;
        repeat (4) next_cycle(); // idle
        masked_ovc_request_all[1:0] = 2'b11; // ivc 0 asks both VCs of port 1
        set_dest(0, 0);
        repeat (3) next_cycle();
        masked_ovc_request_all = '0;
        // ivcs 2, 4, 6 fight for output VC 0 of port 4
        for (int i = 2; i <= 6; i += 2) begin
            masked_ovc_request_all[i*`ALLOC_V] = 1'b1;
            set_dest(i, 3);
        end
        repeat (8) next_cycle();
        masked_ovc_request_all = '0;
        ivc_request_all[3] = 1'b1; // port 1 vc 1 toward port 0
        set_dest(3, 0);
        repeat (4) next_cycle();
        ovc_is_assigned_all[3] = 1'b1;
        repeat (4) next_cycle();
        assigned_ovc_not_full_all[3] = 1'b1;
        repeat (4) next_cycle();
        // ports 0, 2, 3 all aim at port 1
        ivc_request_all = 10'b00_01_01_00_01;
        ovc_is_assigned_all = '1;
        assigned_ovc_not_full_all = '1;
        set_dest(0, 0);
        set_dest(4, 1);
        set_dest(6, 1);
        repeat (8) next_cycle();
        for (int c = 0; c < 500; c++) begin
            for (int i = 0; i < `ALLOC_PV; i++) begin
                set_dest(i, int'(take_bits(2)));
                masked_ovc_request_all[i*`ALLOC_V +: `ALLOC_V] = 2'(take_bits(2));
                ivc_request_all[i] = 1'(take_bits(1));
                ovc_is_assigned_all[i] = 1'(take_bits(1));
                assigned_ovc_not_full_all[i] = 1'(take_bits(1));
            end
            next_cycle();
        end
        @(negedge clk);
        #1;
        $display("errors: %0d mismatch, %0d rule", mismatch_errors, rule_errors);
        if (mismatch_errors == 0 && rule_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
